// ==== src/firbank_pkg.sv ====
package firbank_pkg;

    localparam int COEFF_W   = 24;
    localparam int FRAC_BITS = 23;   // Q1.23

    // Signed filter coefficient
    typedef logic signed [COEFF_W-1:0] coeff_t;

    // Phase-major table, one coefficient per line
    localparam string COEFF_FILE = "src/firbank_coeffs.hex";

endpackage

// ==== src/audio_sample_pkg.sv ====
package audio_sample_pkg;
    import firbank_pkg::*;

    localparam int SAMPLE_W = 24;
    localparam int ACC_W    = 52;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    localparam acc_t SAT_HI = acc_t'((64'sd1 <<< (SAMPLE_W - 1)) - 1);
    localparam acc_t SAT_LO = -SAT_HI - 1;

    // Drop the coefficient fraction, then clip to the sample range
    function automatic sample_t saturate_sample(input acc_t acc);
        acc_t scaled;
        scaled = acc >>> FRAC_BITS;   // Floor
        if (scaled > SAT_HI) begin
            return sample_t'(SAT_HI);
        end else if (scaled < SAT_LO) begin
            return sample_t'(SAT_LO);
        end
        return sample_t'(scaled);
    endfunction

endpackage

// ==== src/firbank_rom.sv ====
module firbank_rom
    import firbank_pkg::*;
#(
    parameter int  FIRDEPTH = 4,
    parameter int  NUM_FIR  = 5,
    localparam int ENTRIES  = NUM_FIR * FIRDEPTH,
    localparam int ADDR_W   = $clog2(ENTRIES)
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr_i,
    output coeff_t            data_o
);

    coeff_t rom [ENTRIES];

    // Table is fixed at elaboration
    initial begin
        $readmemh(COEFF_FILE, rom);
    end

    always_ff @(posedge clk) begin
        data_o <= rom[addr_i];   // One cycle read
    end

endmodule

// ==== src/ringbuf_array.sv ====
module ringbuf_array
    import audio_sample_pkg::*;
#(
    parameter int  NUM_CH   = 2,
    parameter int  RB_DEPTH = 16,
    parameter int  FIRDEPTH = 4,
    localparam int OFF_W    = $clog2(2 * FIRDEPTH)
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [NUM_CH-1:0]          push_i,
    input  logic [NUM_CH*SAMPLE_W-1:0] push_data_i,
    input  logic [NUM_CH-1:0]          pop_i,
    input  logic [NUM_CH*OFF_W-1:0]    offset_i,
    output logic [NUM_CH*SAMPLE_W-1:0] data_o,
    output logic [NUM_CH-1:0]          avail_o,
    output logic [NUM_CH-1:0]          full_o
);

    localparam int PTR_W = $clog2(RB_DEPTH);

    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
        sample_t          mem [RB_DEPTH];
        sample_t          rd_q;
        logic [PTR_W-1:0] wr_ptr_q;
        logic [PTR_W-1:0] rd_ptr_q;   // Oldest sample
        logic [PTR_W-1:0] rd_addr;
        logic [PTR_W:0]   count_q;
        logic             do_push;

        assign do_push = push_i[ch] && !full_o[ch];   // Drop when full
        assign rd_addr = rd_ptr_q + PTR_W'(offset_i[ch*OFF_W +: OFF_W]);

        assign full_o[ch]  = count_q == (PTR_W+1)'(RB_DEPTH);
        assign avail_o[ch] = count_q >= (PTR_W+1)'(2 * FIRDEPTH);
        assign data_o[ch*SAMPLE_W +: SAMPLE_W] = rd_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                if (do_push) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
                if (pop_i[ch]) begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
                // Simultaneous push and pop leave the level unchanged
                if (do_push && !pop_i[ch]) begin
                    count_q <= count_q + 1'b1;
                end else if (!do_push && pop_i[ch]) begin
                    count_q <= count_q - 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (do_push) begin
                mem[wr_ptr_q] <= push_data_i[ch*SAMPLE_W +: SAMPLE_W];
            end
            rd_q <= mem[rd_addr];   // Valid one cycle after the offset
        end
    end

endmodule

// ==== src/mac_accum.sv ====
module mac_accum
    import audio_sample_pkg::*;
    import firbank_pkg::*;
#(
    parameter int MULT_LATENCY = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    clear_i,
    input  logic    valid_i,
    input  coeff_t  coeff_i,
    input  sample_t sample_i,
    output acc_t    acc_o
);

    localparam int PROD_W = COEFF_W + SAMPLE_W;

    logic signed [PROD_W-1:0] prod_q [MULT_LATENCY];
    logic [MULT_LATENCY-1:0]  valid_q;

    // Product pipeline, retimed by synthesis into the multiplier
    always_ff @(posedge clk) begin
        prod_q[0] <= coeff_i * sample_i;
        for (int i = 1; i < MULT_LATENCY; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= valid_i;
            for (int i = 1; i < MULT_LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            acc_o <= '0;
        end else if (valid_q[MULT_LATENCY-1]) begin
            acc_o <= acc_o + acc_t'(prod_q[MULT_LATENCY-1]);
        end
    end

endmodule

// ==== src/resampler_core.sv ====
module resampler_core
    import audio_sample_pkg::*;
    import firbank_pkg::*;
#(
    parameter int  NUM_CH       = 2,
    parameter int  FIRDEPTH     = 4,
    parameter int  NUM_FIR      = 5,
    parameter int  DECIM        = 3,
    parameter int  MULT_LATENCY = 4,
    parameter int  TIMESLICE    = 24,
    localparam int ADDR_W       = $clog2(NUM_FIR * FIRDEPTH),
    localparam int OFF_W        = $clog2(2 * FIRDEPTH)
) (
    input  logic                       clk,
    input  logic                       rst,
    output logic [ADDR_W-1:0]          bank_addr_o,
    input  coeff_t                     bank_data_i,
    output logic [NUM_CH*OFF_W-1:0]    offset_o,
    input  logic [NUM_CH*SAMPLE_W-1:0] data_i,
    input  logic [NUM_CH-1:0]          avail_i,
    output logic [NUM_CH-1:0]          pop_o,
    input  logic [NUM_CH-1:0]          req_i,
    output logic [NUM_CH*SAMPLE_W-1:0] data_o,
    output logic [NUM_CH-1:0]          ack_o
);

    localparam int CH_W      = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
    localparam int SL_W      = $clog2(TIMESLICE);
    localparam int PH_W      = $clog2(NUM_FIR);
    localparam int TAP_W     = $clog2(FIRDEPTH);
    localparam int WING_LAST = FIRDEPTH + MULT_LATENCY;   // Issue plus drain, minus one
    localparam int STEP_W    = $clog2(WING_LAST + 1);

    typedef enum logic [2:0] {
        ST_IDLE, ST_BEGIN, ST_RWING, ST_PREP_L, ST_LWING, ST_END
    } state_t;

    state_t            state_q;
    logic [SL_W-1:0]   slice_q;
    logic [CH_W-1:0]   slot_ch_q;
    logic [NUM_CH-1:0] req_latch_q;
    logic [NUM_CH-1:0] ch_sel;
    logic              start;
    logic [PH_W-1:0]   phase_mem [NUM_CH];
    logic [PH_W-1:0]   phase_q;
    logic [PH_W-1:0]   lphase_q;
    logic [PH_W-1:0]   wing_phase;
    logic [PH_W-1:0]   phase_next;
    logic [PH_W:0]     phase_sum;
    logic              wrap;
    logic [TAP_W-1:0]  tap_q;
    logic [STEP_W-1:0] step_q;
    logic              in_wing;
    logic              issue;
    logic              wing_done;
    logic [OFF_W-1:0]  offset;
    logic              mac_clear;
    logic              mac_valid;
    sample_t           mac_sample;
    acc_t              mac_acc;

    assign ch_sel = NUM_CH'(1) << slot_ch_q;
    assign start  = (state_q == ST_IDLE) && (slice_q == '0) &&
                    req_latch_q[slot_ch_q] && avail_i[slot_ch_q];

    // Fixed time slices, channel 0 first
    always_ff @(posedge clk) begin
        if (rst) begin
            slice_q   <= '0;
            slot_ch_q <= '0;
        end else if (slice_q == SL_W'(TIMESLICE - 1)) begin
            slice_q   <= '0;
            slot_ch_q <= (slot_ch_q == CH_W'(NUM_CH - 1)) ? '0 : slot_ch_q + 1'b1;
        end else begin
            slice_q <= slice_q + 1'b1;
        end
    end

    // A request arriving while its channel is served stays pending
    always_ff @(posedge clk) begin
        if (rst) begin
            req_latch_q <= '0;
        end else begin
            req_latch_q <= (req_latch_q & ~(start ? ch_sel : '0)) | req_i;
        end
    end

    assign in_wing   = (state_q == ST_RWING) || (state_q == ST_LWING);
    assign issue     = in_wing && (step_q < STEP_W'(FIRDEPTH));
    assign wing_done = step_q == STEP_W'(WING_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:   state_q <= start ? ST_BEGIN : ST_IDLE;
                ST_BEGIN:  state_q <= ST_RWING;
                ST_RWING:  state_q <= wing_done ? ST_PREP_L : ST_RWING;
                ST_PREP_L: state_q <= ST_LWING;
                ST_LWING:  state_q <= wing_done ? ST_END : ST_LWING;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    // Right wing walks taps down, left wing walks them up
    always_ff @(posedge clk) begin
        if (rst) begin
            step_q <= '0;
            tap_q  <= '0;
        end else if (state_q == ST_BEGIN || state_q == ST_PREP_L) begin
            step_q <= '0;
            tap_q  <= (state_q == ST_BEGIN) ? TAP_W'(FIRDEPTH - 1) : '0;
        end else if (in_wing) begin
            step_q <= step_q + 1'b1;
            if (issue) begin
                tap_q <= (state_q == ST_RWING) ? tap_q - 1'b1 : tap_q + 1'b1;
            end
        end
    end

    assign phase_sum  = {1'b0, phase_q} + (PH_W+1)'(DECIM);
    assign wrap       = phase_sum >= (PH_W+1)'(NUM_FIR);
    assign phase_next = wrap ? PH_W'(phase_sum - (PH_W+1)'(NUM_FIR)) : PH_W'(phase_sum);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < NUM_CH; c++) begin
                phase_mem[c] <= '0;
            end
        end else if (state_q == ST_END) begin
            phase_mem[slot_ch_q] <= phase_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_BEGIN) begin
            phase_q <= phase_mem[slot_ch_q];
        end
        if (state_q == ST_PREP_L) begin
            lphase_q <= PH_W'(NUM_FIR - 1) - phase_q;   // Mirrored branch
        end
    end

    assign wing_phase  = (state_q == ST_LWING) ? lphase_q : phase_q;
    assign bank_addr_o = ADDR_W'(wing_phase) * ADDR_W'(FIRDEPTH) + ADDR_W'(tap_q);
    assign offset      = (state_q == ST_LWING) ? OFF_W'(FIRDEPTH - 1) - OFF_W'(tap_q)
                                               : OFF_W'(FIRDEPTH) + OFF_W'(tap_q);
    assign offset_o    = {NUM_CH{offset}};   // Only the slot owner's lane is used

    // ROM and buffer data arrive one cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            mac_valid <= 1'b0;
        end else begin
            mac_valid <= issue;
        end
    end

    assign mac_clear  = state_q == ST_BEGIN;
    assign mac_sample = data_i[slot_ch_q*SAMPLE_W +: SAMPLE_W];

    mac_accum #(
        .MULT_LATENCY(MULT_LATENCY)
    ) u_mac (
        .clk      (clk),
        .rst      (rst),
        .clear_i  (mac_clear),
        .valid_i  (mac_valid),
        .coeff_i  (bank_data_i),
        .sample_i (mac_sample),
        .acc_o    (mac_acc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            data_o <= '0;
            ack_o  <= '0;
        end else begin
            ack_o <= (state_q == ST_END) ? ch_sel : '0;
            if (state_q == ST_END) begin
                data_o[slot_ch_q*SAMPLE_W +: SAMPLE_W] <= saturate_sample(mac_acc);
            end
        end
    end

    assign pop_o = (state_q == ST_END && wrap) ? ch_sel : '0;   // Oldest sample retires on wrap

endmodule

// ==== src/resampler_top.sv ====
module resampler_top
    import audio_sample_pkg::*;
    import firbank_pkg::*;
#(
    parameter int  NUM_CH       = 2,
    parameter int  FIRDEPTH     = 4,
    parameter int  NUM_FIR      = 5,
    parameter int  DECIM        = 3,
    parameter int  MULT_LATENCY = 4,
    parameter int  TIMESLICE    = 24,
    parameter int  RB_DEPTH     = 16,
    localparam int ADDR_W       = $clog2(NUM_FIR * FIRDEPTH),
    localparam int OFF_W        = $clog2(2 * FIRDEPTH)
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [NUM_CH-1:0]          push_i,
    input  logic [NUM_CH*SAMPLE_W-1:0] push_data_i,
    input  logic [NUM_CH-1:0]          req_i,
    output logic [NUM_CH-1:0]          full_o,
    output logic [NUM_CH*SAMPLE_W-1:0] data_o,
    output logic [NUM_CH-1:0]          ack_o
);

    logic [ADDR_W-1:0]          bank_addr;
    coeff_t                     bank_data;
    logic [NUM_CH*OFF_W-1:0]    rb_offset;
    logic [NUM_CH*SAMPLE_W-1:0] rb_data;
    logic [NUM_CH-1:0]          rb_avail;
    logic [NUM_CH-1:0]          rb_pop;

    resampler_core #(
        .NUM_CH       (NUM_CH),
        .FIRDEPTH     (FIRDEPTH),
        .NUM_FIR      (NUM_FIR),
        .DECIM        (DECIM),
        .MULT_LATENCY (MULT_LATENCY),
        .TIMESLICE    (TIMESLICE)
    ) u_core (
        .clk         (clk),
        .rst         (rst),
        .bank_addr_o (bank_addr),
        .bank_data_i (bank_data),
        .offset_o    (rb_offset),
        .data_i      (rb_data),
        .avail_i     (rb_avail),
        .pop_o       (rb_pop),
        .req_i       (req_i),
        .data_o      (data_o),
        .ack_o       (ack_o)
    );

    firbank_rom #(
        .FIRDEPTH (FIRDEPTH),
        .NUM_FIR  (NUM_FIR)
    ) u_rom (
        .clk    (clk),
        .addr_i (bank_addr),
        .data_o (bank_data)
    );

    ringbuf_array #(
        .NUM_CH   (NUM_CH),
        .RB_DEPTH (RB_DEPTH),
        .FIRDEPTH (FIRDEPTH)
    ) u_ringbuf (
        .clk         (clk),
        .rst         (rst),
        .push_i      (push_i),
        .push_data_i (push_data_i),
        .pop_i       (rb_pop),
        .offset_i    (rb_offset),
        .data_o      (rb_data),
        .avail_o     (rb_avail),
        .full_o      (full_o)
    );

endmodule

// ==== tb/resampler_model.svh ====
`ifndef RESAMPLER_MODEL_SVH
`define RESAMPLER_MODEL_SVH

coeff_t  coeff_tab [NUM_FIR*FIRDEPTH];
sample_t hist_mem  [NUM_CH][RB_DEPTH];   // Mirrored input history
int      hist_head [NUM_CH];
int      hist_cnt  [NUM_CH];
int      phase_m   [NUM_CH];
bit      pending_m [NUM_CH];

task automatic reset_model();
    $readmemh(COEFF_FILE, coeff_tab);
    for (int c = 0; c < NUM_CH; c++) begin
        hist_head[c] = 0;
        hist_cnt[c]  = 0;
        phase_m[c]   = 0;
        pending_m[c] = 1'b0;
    end
endtask

// A push into a full buffer is lost
function automatic void accept_push(input int ch, input sample_t s);
    if (hist_cnt[ch] < RB_DEPTH) begin
        hist_mem[ch][(hist_head[ch] + hist_cnt[ch]) % RB_DEPTH] = s;
        hist_cnt[ch]++;
    end
endfunction

function automatic longint history(input int ch, input int j);
    return longint'(hist_mem[ch][(hist_head[ch] + j) % RB_DEPTH]);
endfunction

// Symmetric FIR at the current phase, then phase step and pop on wrap
function automatic sample_t predict_output(input int ch);
    longint acc;
    int     p;
    int     q;
    acc = 0;
    p   = phase_m[ch];
    q   = NUM_FIR - 1 - p;   // Mirrored branch for the left wing
    for (int k = 0; k < FIRDEPTH; k++) begin
        acc += longint'(coeff_tab[p*FIRDEPTH + k]) * history(ch, FIRDEPTH + k);
        acc += longint'(coeff_tab[q*FIRDEPTH + k]) * history(ch, FIRDEPTH - 1 - k);
    end
    phase_m[ch] = p + DECIM;
    if (phase_m[ch] >= NUM_FIR) begin
        phase_m[ch]  -= NUM_FIR;
        hist_head[ch] = (hist_head[ch] + 1) % RB_DEPTH;
        hist_cnt[ch]--;
    end
    return saturate_sample(acc_t'(acc));
endfunction

`endif

// ==== tb/tb_resampler.sv ====
module tb_resampler
    import audio_sample_pkg::*;
    import firbank_pkg::*;
();

    localparam int NUM_CH       = 2;
    localparam int FIRDEPTH     = 4;
    localparam int NUM_FIR      = 5;
    localparam int DECIM        = 3;
    localparam int MULT_LATENCY = 4;
    localparam int TIMESLICE    = 24;
    localparam int RB_DEPTH     = 16;

    localparam int SINGLE_REQS = 30;
    localparam int DUAL_REQS   = 12;   // Per channel
    localparam int FULL_REQS   = 6;
    localparam int SAT_REQS    = 20;   // Per sign
    localparam int REQ_TOTAL   = 1 + SINGLE_REQS + 2*DUAL_REQS + FULL_REQS + 2*SAT_REQS;
    localparam int IDLE_WAIT   = 4 * TIMESLICE;
    localparam int PUSH_CYCLES = REQ_TOTAL*RB_DEPTH + 2*RB_DEPTH + IDLE_WAIT + 16;
    localparam int CYCLE_LIMIT = REQ_TOTAL*(NUM_CH+1)*TIMESLICE + PUSH_CYCLES + 200;

    localparam sample_t FULL_POS = sample_t'(24'h7FFFFF);
    localparam sample_t FULL_NEG = sample_t'(24'h800000);

    logic                       clk;
    logic                       rst;
    logic [NUM_CH-1:0]          push;
    logic [NUM_CH*SAMPLE_W-1:0] push_data;
    logic [NUM_CH-1:0]          req;
    logic [NUM_CH-1:0]          full;
    logic [NUM_CH*SAMPLE_W-1:0] data_out;
    logic [NUM_CH-1:0]          ack;

    integer seed;
    int     cycle_cnt    = 0;
    int     mismatch_cnt = 0;
    int     other_cnt    = 0;
    int     ack_cnt      = 0;
    int     pos_clips    = 0;
    int     neg_clips    = 0;
    int     acks_before;

    `include "resampler_model.svh"

    resampler_top #(
        .NUM_CH       (NUM_CH),
        .FIRDEPTH     (FIRDEPTH),
        .NUM_FIR      (NUM_FIR),
        .DECIM        (DECIM),
        .MULT_LATENCY (MULT_LATENCY),
        .TIMESLICE    (TIMESLICE),
        .RB_DEPTH     (RB_DEPTH)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .push_i      (push),
        .push_data_i (push_data),
        .req_i       (req),
        .full_o      (full),
        .data_o      (data_out),
        .ack_o       (ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic signed [63:0] got,
                               input logic signed [63:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        other_cnt++;
        $display("error at %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            report_failure($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
            finish_run();
        end
    end

    // Ack and full flag checks against the model
    task automatic service_acks();
        sample_t exp;
        for (int c = 0; c < NUM_CH; c++) begin
            if (ack[c] === 1'b1) begin
                ack_cnt++;
                if (!pending_m[c]) begin
                    report_failure($sformatf("ack on channel %0d with no request pending", c));
                end else if (hist_cnt[c] < 2*FIRDEPTH) begin
                    report_failure($sformatf("ack on channel %0d with too few samples", c));
                end else begin
                    pending_m[c] = 1'b0;
                    exp = predict_output(c);
                    pos_clips += (exp == FULL_POS);
                    neg_clips += (exp == FULL_NEG);
                    check_value($sformatf("data_o[%0d]", c),
                                sample_t'(data_out[c*SAMPLE_W +: SAMPLE_W]), exp);
                end
            end
            check_value($sformatf("full_o[%0d]", c), full[c], hist_cnt[c] == RB_DEPTH);
        end
    endtask

    task automatic drive_cycle(input logic [NUM_CH-1:0] push_mask,
                               input logic [NUM_CH*SAMPLE_W-1:0] samples,
                               input logic [NUM_CH-1:0] req_mask);
        @(negedge clk);
        service_acks();
        for (int c = 0; c < NUM_CH; c++) begin
            if (push_mask[c]) begin
                accept_push(c, samples[c*SAMPLE_W +: SAMPLE_W]);
            end
            if (req_mask[c]) begin
                pending_m[c] = 1'b1;
            end
        end
        push      = push_mask;
        push_data = samples;
        req       = req_mask;
    endtask

    function automatic logic [NUM_CH*SAMPLE_W-1:0] random_samples();
        logic [NUM_CH*SAMPLE_W-1:0] v;
        for (int c = 0; c < NUM_CH; c++) begin
            v[c*SAMPLE_W +: SAMPLE_W] = sample_t'($random(seed));
        end
        return v;
    endfunction

    // Push until each masked channel holds at least level samples
    task automatic top_up(input logic [NUM_CH-1:0] mask, input int level,
                          input bit fixed, input sample_t value);
        logic [NUM_CH-1:0]          need;
        logic [NUM_CH*SAMPLE_W-1:0] samples;
        need = mask;
        while (need != '0) begin
            samples = fixed ? {NUM_CH{value}} : random_samples();
            for (int c = 0; c < NUM_CH; c++) begin
                need[c] = mask[c] && (hist_cnt[c] < level);
            end
            if (need != '0) begin
                drive_cycle(need, samples, '0);
            end
        end
    endtask

    // Idle until every masked channel has been acknowledged
    task automatic wait_for_acks(input logic [NUM_CH-1:0] mask);
        bit busy;
        busy = 1'b1;
        while (busy) begin
            drive_cycle('0, '0, '0);
            busy = 1'b0;
            for (int c = 0; c < NUM_CH; c++) begin
                busy |= mask[c] && pending_m[c];
            end
        end
    endtask

    task automatic request_and_wait(input logic [NUM_CH-1:0] mask);
        drive_cycle('0, '0, mask);
        wait_for_acks(mask);
    endtask

    task automatic run_requests(input logic [NUM_CH-1:0] mask, input int count,
                                input bit fixed, input sample_t value);
        repeat (count) begin
            top_up(mask, 2*FIRDEPTH + ($random(seed) & 3), fixed, value);
            request_and_wait(mask);
        end
    endtask

    initial begin
        seed      = 32'h8476;
        rst       = 1'b1;
        push      = '0;
        push_data = '0;
        req       = '0;
        reset_model();
        repeat (16) @(negedge clk);
        check_value("ack_o", ack, 0);
        check_value("full_o", full, 0);
        check_value("data_o", data_out, 0);
        rst = 1'b0;

        // Request with too little history waits for more samples
        top_up(2'b10, 2*FIRDEPTH - 3, 1'b0, '0);
        drive_cycle('0, '0, 2'b10);
        acks_before = ack_cnt;
        repeat (IDLE_WAIT) drive_cycle('0, '0, '0);
        if (ack_cnt != acks_before) begin
            report_failure("ack on channel 1 before enough samples were buffered");
        end
        top_up(2'b10, 2*FIRDEPTH, 1'b0, '0);
        wait_for_acks(2'b10);

        run_requests(2'b01, SINGLE_REQS, 1'b0, '0);
        run_requests(2'b11, DUAL_REQS, 1'b0, '0);   // Independent streams

        // Fill channel 0 and keep pushing into the full buffer
        for (int i = 0; i <= RB_DEPTH && full[0] !== 1'b1; i++) begin
            drive_cycle(2'b01, random_samples(), '0);
        end
        if (full[0] !== 1'b1) begin
            report_failure("full_o on channel 0 never rose");
        end
        repeat (4) drive_cycle(2'b01, random_samples(), '0);
        repeat (FULL_REQS) request_and_wait(2'b01);

        pos_clips = 0;
        neg_clips = 0;
        run_requests(2'b10, SAT_REQS, 1'b1, FULL_POS);
        run_requests(2'b10, SAT_REQS, 1'b1, FULL_NEG);
        if (pos_clips == 0 || neg_clips == 0) begin
            report_failure("full-scale input never drove the output into saturation");
        end

        drive_cycle('0, '0, '0);
        finish_run();
    end

endmodule

// ==== src/firbank_coeffs.hex ====
// Q1.23 coefficient per line, entry = phase * FIRDEPTH + tap
400000
300000
100000
F80000
3C0000
2C0000
0E0000
FA0000
380000
280000
0C0000
FC0000
340000
240000
0A0000
FE0000
300000
200000
080000
000000

// ==== filelist.f ====
+incdir+tb
src/firbank_pkg.sv
src/audio_sample_pkg.sv
src/firbank_rom.sv
src/ringbuf_array.sv
src/mac_accum.sv
src/resampler_core.sv
src/resampler_top.sv
tb/tb_resampler.sv
